/* rtl/dcachePkg.sv */
//////////////////////////////////////////////////////////////////////
// sizes, address fields and bus types for the direct-mapped L1 cache
// all accesses are full 32-bit words on word-aligned addresses
//////////////////////////////////////////////////////////////////////
package dcachePkg;

	localparam int xlen = 32;
	localparam int paBits = 32;
	localparam int lineWords = 4;
	localparam int numLines = 16;

	// address split: tag | index | word | byte
	localparam int byteBits = $clog2(xlen / 8);
	localparam int wordBits = $clog2(lineWords);
	localparam int offsetBits = byteBits + wordBits;
	localparam int indexBits = $clog2(numLines);
	localparam int tagBits = paBits - indexBits - offsetBits;

	typedef logic [xlen-1:0] wordT;
	typedef logic [paBits-1:0] addrT;
	typedef logic [indexBits-1:0] indexT;
	typedef logic [tagBits-1:0] tagT;
	typedef wordT [lineWords-1:0] lineT;

	typedef struct packed {
		logic valid;
		logic dirty;
		tagT tag;
	} tagEntryT;

	typedef struct packed {
		logic read;
		logic write;
		logic cacheable;
		addrT addr;
		wordT wdata;
	} cpuReqT;

	typedef struct packed {
		logic read;
		logic write;
		addrT addr;
		wordT wdata;
	} busReqT;

	typedef struct packed {
		logic ack;
		wordT rdata;
	} busRspT;

	typedef enum logic [2:0] {
		busIdle,
		busWriteBack,
		busRefill,
		busSingleRead,
		busSingleWrite
	} busModeT;

	function automatic tagT addrTag(addrT addr);
		return addr[paBits-1 -: tagBits];
	endfunction

	function automatic indexT addrIndex(addrT addr);
		return addr[offsetBits +: indexBits];
	endfunction

	function automatic logic [wordBits-1:0] addrWord(addrT addr);
		return addr[byteBits +: wordBits];
	endfunction

endpackage

/* rtl/cacheArray.sv */
//////////////////////////////////////////////////////////////////////
// register array, combinational read, one write port per clock
// reset clears every entry, so a tag store starts invalid and clean
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cacheArray #(
	parameter int depth = 16,
	parameter type payloadT = dcachePkg::wordT
) (
	input logic clk,
	input logic reset,
	input dcachePkg::indexT readIndex,
	output payloadT readEntry,
	input logic writeEnable,
	input dcachePkg::indexT writeIndex,
	input payloadT writeEntry
);

	payloadT entries [depth];

	// read port has no clock, the controller sees the entry in the same cycle
	assign readEntry = entries[readIndex];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				entries[i] <= '0;
			end
		end else if (writeEnable) begin
			entries[writeIndex] <= writeEntry;
		end
	end

endmodule

/* rtl/busEngine.sv */
//////////////////////////////////////////////////////////////////////
// memory bus master, one word per beat, request held until ack
// busMode must stay steady for the whole transfer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module busEngine (
	input logic clk,
	input logic reset,
	input dcachePkg::busModeT busMode,
	input dcachePkg::cpuReqT cpuReq,
	input dcachePkg::lineT victimLine,
	input dcachePkg::tagT victimTag,
	output dcachePkg::busReqT busReq,
	input dcachePkg::busRspT busRsp,
	output logic busDone,
	output dcachePkg::lineT fillLine
);
	import dcachePkg::*;

	logic [wordBits-1:0] beatCount;
	logic [wordBits-1:0] fillSlot;
	logic singleBeat;
	logic lastBeat;
	logic beatAck;

	assign singleBeat = (busMode == busSingleRead) || (busMode == busSingleWrite);
	assign beatAck = busRsp.ack && (busMode != busIdle);
	assign lastBeat = singleBeat || (beatCount == wordBits'(lineWords - 1));
	assign busDone = beatAck && lastBeat;

	// counter wraps after the last line beat, so a refill may follow directly
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			beatCount <= '0;
		end else if (busMode == busIdle) begin
			beatCount <= '0;
		end else if (beatAck) begin
			beatCount <= beatCount + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// beat address and write data
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		busReq = '0;
		case (busMode)
			busWriteBack: begin
				busReq.write = 1'b1;
				busReq.addr = {victimTag, addrIndex(cpuReq.addr), beatCount, {byteBits{1'b0}}};
				busReq.wdata = victimLine[beatCount];
			end
			busRefill: begin
				busReq.read = 1'b1;
				busReq.addr = {addrTag(cpuReq.addr), addrIndex(cpuReq.addr), beatCount,
					{byteBits{1'b0}}};
			end
			busSingleRead: begin
				busReq.read = 1'b1;
				busReq.addr = cpuReq.addr;
			end
			busSingleWrite: begin
				busReq.write = 1'b1;
				busReq.addr = cpuReq.addr;
				busReq.wdata = cpuReq.wdata;
			end
			default: begin
			end
		endcase
	end

	// an uncached read lands in word 0
	assign fillSlot = (busMode == busSingleRead) ? '0 : beatCount;

	always_ff @(posedge clk) begin
		if (beatAck && busReq.read) begin
			fillLine[fillSlot] <= busRsp.rdata;
		end
	end

endmodule

/* rtl/cacheDatapath.sv */
//////////////////////////////////////////////////////////////////////
// read word select, write merge and the CPU read-data register
// readData keeps its value until the next completed read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cacheDatapath (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	input dcachePkg::lineT storedLine,
	input dcachePkg::lineT fillLine,
	input logic refillSel,
	input logic uncachedSel,
	input logic readLoad,
	output dcachePkg::lineT writeLine,
	output dcachePkg::wordT readData
);
	import dcachePkg::*;

	logic [wordBits-1:0] wordSel;
	wordT nextRead;
	lineT mergedLine;

	assign wordSel = addrWord(cpuReq.addr);
	assign nextRead = uncachedSel ? fillLine[0] : storedLine[wordSel];

	// a write hit replaces one word and keeps the rest of the line
	always_comb begin
		mergedLine = storedLine;
		mergedLine[wordSel] = cpuReq.wdata;
	end

	assign writeLine = refillSel ? fillLine : mergedLine;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			readData <= '0;
		end else if (readLoad) begin
			readData <= nextRead;
		end
	end

endmodule

/* rtl/cacheController.sv */
//////////////////////////////////////////////////////////////////////
// cache FSM for hit, write-back, refill and uncached word access
// the CPU must hold cpuReq steady while stall is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cacheController (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	input dcachePkg::tagEntryT tagEntry,
	input logic busDone,
	output logic stall,
	output dcachePkg::busModeT busMode,
	output logic lineWrite,
	output logic tagWrite,
	output dcachePkg::tagEntryT newTagEntry,
	output logic refillSel,
	output logic uncachedSel,
	output logic readLoad
);
	import dcachePkg::*;

	typedef enum logic [2:0] {
		idle,
		writeBack,
		refill,
		fillWrite,
		uncachedDone
	} stateT;

	stateT state;
	stateT nextState;
	logic anyReq;
	logic hit;
	logic victimDirty;

	assign anyReq = cpuReq.read || cpuReq.write;
	assign hit = tagEntry.valid && (tagEntry.tag == addrTag(cpuReq.addr));
	assign victimDirty = tagEntry.valid && tagEntry.dirty;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		stall = 1'b0;
		busMode = busIdle;
		lineWrite = 1'b0;
		tagWrite = 1'b0;
		refillSel = 1'b0;
		uncachedSel = 1'b0;
		readLoad = 1'b0;
		newTagEntry.valid = 1'b1;
		newTagEntry.dirty = 1'b0;
		newTagEntry.tag = addrTag(cpuReq.addr);

		case (state)
			idle: begin
				if (anyReq && !cpuReq.cacheable) begin
					// single beat runs here, completion is in uncachedDone
					stall = 1'b1;
					busMode = cpuReq.write ? busSingleWrite : busSingleRead;
					if (busDone) begin
						nextState = uncachedDone;
					end
				end else if (anyReq && hit) begin
					readLoad = cpuReq.read;
					lineWrite = cpuReq.write;
					tagWrite = cpuReq.write;
					newTagEntry.dirty = 1'b1;
				end else if (anyReq) begin
					stall = 1'b1;
					nextState = victimDirty ? writeBack : refill;
				end
			end
			writeBack: begin
				stall = 1'b1;
				busMode = busWriteBack;
				if (busDone) begin
					nextState = refill;
				end
			end
			refill: begin
				stall = 1'b1;
				busMode = busRefill;
				if (busDone) begin
					nextState = fillWrite;
				end
			end
			fillWrite: begin
				// fresh line is clean, the request then hits in idle
				stall = 1'b1;
				refillSel = 1'b1;
				lineWrite = 1'b1;
				tagWrite = 1'b1;
				nextState = idle;
			end
			uncachedDone: begin
				uncachedSel = 1'b1;
				readLoad = cpuReq.read;
				nextState = idle;
			end
			default: begin
				nextState = idle;
			end
		endcase
	end

endmodule

/* rtl/dataCache.sv */
//////////////////////////////////////////////////////////////////////
// direct-mapped write-back L1 data cache, 16 lines of 4 words
// no sub-word, atomic or page-walker accesses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dataCache (
	input logic clk,
	input logic reset,
	input dcachePkg::cpuReqT cpuReq,
	output logic stall,
	output dcachePkg::wordT readData,
	output dcachePkg::busReqT busReq,
	input dcachePkg::busRspT busRsp
);
	import dcachePkg::*;

	indexT lineIndex;
	lineT storedLine;
	lineT writeLine;
	lineT fillLine;
	tagEntryT tagEntry;
	tagEntryT newTagEntry;
	busModeT busMode;
	logic busDone;
	logic lineWrite;
	logic tagWrite;
	logic refillSel;
	logic uncachedSel;
	logic readLoad;

	// both arrays are read and written at the request's index
	assign lineIndex = addrIndex(cpuReq.addr);

	cacheController controller (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.tagEntry(tagEntry),
		.busDone(busDone),
		.stall(stall),
		.busMode(busMode),
		.lineWrite(lineWrite),
		.tagWrite(tagWrite),
		.newTagEntry(newTagEntry),
		.refillSel(refillSel),
		.uncachedSel(uncachedSel),
		.readLoad(readLoad)
	);

	cacheDatapath datapath (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.storedLine(storedLine),
		.fillLine(fillLine),
		.refillSel(refillSel),
		.uncachedSel(uncachedSel),
		.readLoad(readLoad),
		.writeLine(writeLine),
		.readData(readData)
	);

	busEngine engine (
		.clk(clk),
		.reset(reset),
		.busMode(busMode),
		.cpuReq(cpuReq),
		.victimLine(storedLine),
		.victimTag(tagEntry.tag),
		.busReq(busReq),
		.busRsp(busRsp),
		.busDone(busDone),
		.fillLine(fillLine)
	);

	cacheArray #(
		.depth(numLines),
		.payloadT(lineT)
	) dataArray (
		.clk(clk),
		.reset(reset),
		.readIndex(lineIndex),
		.readEntry(storedLine),
		.writeEnable(lineWrite),
		.writeIndex(lineIndex),
		.writeEntry(writeLine)
	);

	cacheArray #(
		.depth(numLines),
		.payloadT(tagEntryT)
	) tagArray (
		.clk(clk),
		.reset(reset),
		.readIndex(lineIndex),
		.readEntry(tagEntry),
		.writeEnable(tagWrite),
		.writeIndex(lineIndex),
		.writeEntry(newTagEntry)
	);

endmodule

/* tests/tbClock.sv */
//////////////////////////////////////////////////////////////////////
// free-running testbench clock, 4 ns period, starts low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

endmodule

/* tests/memoryModel.sv */
//////////////////////////////////////////////////////////////////////
// word memory on the cache bus, ack after 0 to 3 idle cycles
// an unwritten word reads as its address xor 32'h5a5a_a5a5
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module memoryModel (
	input logic clk,
	input dcachePkg::busReqT busReq,
	output dcachePkg::busRspT busRsp
);
	import dcachePkg::*;

	wordT words [addrT];
	integer seed;
	int delay;
	busReqT beat;

	function automatic wordT fetchWord(addrT addr);
		if (words.exists(addr)) begin
			return words[addr];
		end
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	initial begin
		seed = 32'h84be_3f4b;
		busRsp = '0;
		forever begin
			// request is sampled mid-cycle, where it is stable
			@(negedge clk);
			if (busReq.read || busReq.write) begin
				beat = busReq;
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clk);
				@(posedge clk);
				#1;
				busRsp.ack = 1'b1;
				if (beat.write) begin
					words[beat.addr] = beat.wdata;
				end else begin
					busRsp.rdata = fetchWord(beat.addr);
				end
				// one-cycle ack pulse
				@(posedge clk);
				#1;
				busRsp = '0;
			end
		end
	end

endmodule

/* tests/dataCacheTb.sv */
//////////////////////////////////////////////////////////////////////
// directed table entries first, then 40 random cached accesses
// cached and uncached addresses never share a line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dataCacheTb;
	import dcachePkg::*;

	localparam int stallLimit = 200;
	localparam int randomEntries = 40;

	typedef struct packed {
		logic isWrite;
		logic cacheable;
		addrT addr;
		wordT wdata;
		wordT expData;
		logic expHit;
	} stimEntryT;

	logic clk;
	logic reset;
	cpuReqT cpuReq;
	logic stall;
	wordT readData;
	busReqT busReq;
	busRspT busRsp;

	stimEntryT stimulus[$];
	// reference memory and a direct-mapped tag model for hit prediction
	wordT refMem [addrT];
	logic lineValid [numLines];
	tagT lineTag [numLines];
	integer seed;
	int entryNum;

	tbClock clockGen (
		.clk(clk)
	);

	memoryModel memory (
		.clk(clk),
		.busReq(busReq),
		.busRsp(busRsp)
	);

	dataCache uut (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.stall(stall),
		.readData(readData),
		.busReq(busReq),
		.busRsp(busRsp)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model and stimulus table
	//////////////////////////////////////////////////////////////////////
	function automatic wordT refRead(addrT addr);
		if (refMem.exists(addr)) begin
			return refMem[addr];
		end
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	function automatic void addEntry(logic isWrite, logic cacheable, addrT addr, wordT wdata);
		stimEntryT e;
		indexT idx;
		tagT tag;
		idx = addr[offsetBits +: indexBits];
		tag = addr[paBits-1 -: tagBits];
		e.isWrite = isWrite;
		e.cacheable = cacheable;
		e.addr = addr;
		e.wdata = wdata;
		e.expHit = cacheable && lineValid[idx] && (lineTag[idx] == tag);
		// a cached miss allocates the line, uncached access leaves tags alone
		if (cacheable && !e.expHit) begin
			lineValid[idx] = 1'b1;
			lineTag[idx] = tag;
		end
		e.expData = isWrite ? '0 : refRead(addr);
		if (isWrite) begin
			refMem[addr] = wdata;
		end
		stimulus.push_back(e);
	endfunction

	function automatic addrT randomAddr();
		int pick;
		tagT tag;
		indexT idx;
		logic [wordBits-1:0] word;
		pick = ($random(seed) & 32'h7fff_ffff) % 3;
		tag = tagT'(24'h000400 + pick);
		idx = indexT'($random(seed) & 3);
		word = wordBits'($random(seed) & 3);
		return {tag, idx, word, {byteBits{1'b0}}};
	endfunction

	function automatic void buildTable();
		for (int i = 0; i < numLines; i++) begin
			lineValid[i] = 1'b0;
			lineTag[i] = '0;
		end
		// cold miss, then a hit in the same line
		addEntry(1'b0, 1'b1, 32'h0000_1040, '0);
		addEntry(1'b0, 1'b1, 32'h0000_1048, '0);
		// write hit makes the line dirty
		addEntry(1'b1, 1'b1, 32'h0000_1044, 32'hdead_beef);
		addEntry(1'b0, 1'b1, 32'h0000_1044, '0);
		// same index, new tag forces the write-back
		addEntry(1'b0, 1'b1, 32'h0000_2040, '0);
		addEntry(1'b0, 1'b1, 32'h0000_1044, '0);
		// uncached pair, then the cached line must still hit
		addEntry(1'b1, 1'b0, 32'h0000_3000, 32'h1234_5678);
		addEntry(1'b0, 1'b0, 32'h0000_3000, '0);
		addEntry(1'b0, 1'b1, 32'h0000_1048, '0);
		for (int i = 0; i < randomEntries; i++) begin
			addEntry(($random(seed) & 1) == 1, 1'b1, randomAddr(), $random(seed));
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks and entry execution
	//////////////////////////////////////////////////////////////////////
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		if (got !== exp) begin
			failRun($sformatf("** Error: %s = %h, expected %h on table entry %0d",
				name, got, exp, entryNum));
		end
	endtask

	task automatic checkHit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("** Error: %s = %h, expected %h on table entry %0d",
				name, got, exp, entryNum));
		end
	endtask

	// called 1 ns after a rising edge, returns 1 ns after the completing edge
	task automatic runEntry(input stimEntryT e);
		int cycles;
		logic stalled;
		cpuReq.read = !e.isWrite;
		cpuReq.write = e.isWrite;
		cpuReq.cacheable = e.cacheable;
		cpuReq.addr = e.addr;
		cpuReq.wdata = e.wdata;
		#1;
		stalled = stall;
		cycles = 0;
		while (stall) begin
			@(posedge clk);
			#2;
			cycles++;
			if (cycles > stallLimit) begin
				failRun($sformatf("stall stayed high for more than %0d cycles on table entry %0d",
					stallLimit, entryNum));
			end
		end
		// stall is low, the request completes on this edge
		@(posedge clk);
		#1;
		checkHit("hit", !stalled, e.expHit);
		if (!e.isWrite) begin
			checkWord("readData", readData, e.expData);
		end
	endtask

	initial begin
		seed = 32'h84be_3f4b;
		reset = 1'b1;
		cpuReq = '0;
		buildTable();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		for (entryNum = 0; entryNum < stimulus.size(); entryNum++) begin
			runEntry(stimulus[entryNum]);
		end
		cpuReq = '0;
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* filelist.f */
rtl/dcachePkg.sv
rtl/cacheArray.sv
rtl/busEngine.sv
rtl/cacheDatapath.sv
rtl/cacheController.sv
rtl/dataCache.sv
tests/tbClock.sv
tests/memoryModel.sv
tests/dataCacheTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS := --binary --timing -j 0
TOP := dataCacheTb
FILELIST := filelist.f
OBJDIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
